//--- cpu_top.f
design/cpu_pkg.sv
design/reg_file.sv
design/insn_decode.sv
design/exec_unit.sv
design/cpu_core.sv
design/unified_mem.sv
design/cpu_top.sv
test/tb_clock.sv
test/cpu_top_tb.sv

//--- design/cpu_core.sv
`timescale 1ns/10ps

module cpu_core import cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_start,
    input  logic [XLEN-1:0]   i_insn,
    input  logic [XLEN-1:0]   i_mem_rdata,
    output logic [MEM_AW-1:0] o_insn_addr,
    output logic [MEM_AW-1:0] o_mem_addr,
    output logic              o_mem_we,
    output logic [XLEN-1:0]   o_mem_wdata,
    output logic              o_running,
    output logic              o_halt
);

    core_state_e       state;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   next_pc;

    logic [REG_AW-1:0] z_idx;
    logic [REG_AW-1:0] x_idx;
    logic [REG_AW-1:0] y_idx;
    logic [XLEN-1:0]   imm;
    alu_op_e           op;
    deref_e            deref;
    logic              insn_type;
    logic              is_op;
    logic              illegal;

    logic [XLEN-1:0]   rd_x;
    logic [XLEN-1:0]   rd_y;
    logic [XLEN-1:0]   rd_z;
    logic [XLEN-1:0]   rhs;
    logic [XLEN-1:0]   wb_data;

    logic              op_en;
    logic              reg_we;
    logic              jump;

    insn_decode u_decode (
        .i_insn    (i_insn),
        .o_z_idx   (z_idx),
        .o_x_idx   (x_idx),
        .o_y_idx   (y_idx),
        .o_imm     (imm),
        .o_op      (op),
        .o_deref   (deref),
        .o_type    (insn_type),
        .o_is_op   (is_op),
        .o_illegal (illegal)
    );

    reg_file u_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_rd_x_idx (x_idx),
        .i_rd_y_idx (y_idx),
        .i_rd_z_idx (z_idx),
        .i_pc       (pc),
        .i_wr_en    (reg_we),
        .i_wr_idx   (z_idx),
        .i_wr_data  (wb_data),
        .o_rd_x     (rd_x),
        .o_rd_y     (rd_y),
        .o_rd_z     (rd_z)
    );

    exec_unit u_exec (
        .i_x    (rd_x),
        .i_y    (rd_y),
        .i_imm  (imm),
        .i_op   (op),
        .i_type (insn_type),
        .o_rhs  (rhs)
    );

    assign op_en = (state == ST_RUN) && is_op;

    // Register destinations for DR_REG and DR_LOAD, r0 writes dropped
    assign reg_we  = op_en && !deref[1] && (z_idx != '0);
    assign jump    = reg_we && (z_idx == REG_AW'(PC_INDEX));
    assign wb_data = (deref == DR_LOAD) ? i_mem_rdata : rhs;
    assign next_pc = jump ? wb_data : pc + 1'b1;

    // Address is Z only for DR_STORE_Z, otherwise rhs
    assign o_mem_we    = op_en && deref[1];
    assign o_mem_addr  = (deref == DR_STORE_Z) ? rd_z[MEM_AW-1:0] : rhs[MEM_AW-1:0];
    assign o_mem_wdata = (deref == DR_STORE_Z) ? rhs : rd_z;
    assign o_insn_addr = pc[MEM_AW-1:0];

    assign o_running = (state == ST_RUN);
    assign o_halt    = (state == ST_HALT);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= ST_IDLE;
            pc    <= RESET_VECTOR;
        end else begin
            case (state)
                ST_IDLE: if (i_start) begin
                    state <= ST_RUN;
                    pc    <= RESET_VECTOR;
                end
                ST_RUN: begin
                    if (illegal)
                        state <= ST_HALT; // PC frozen on the bad word
                    else
                        pc <= next_pc;
                end
                default: state <= state; // Halt holds until reset
            endcase
        end
    end

endmodule

//--- design/cpu_pkg.sv
package cpu_pkg;

    // Datapath and address width
    localparam int XLEN = 32;

    // Register file
    localparam int REG_COUNT = 16;
    localparam int REG_AW    = $clog2(REG_COUNT);
    localparam int PC_INDEX  = 15; // Reads as PC, writes jump

    // Unified memory, word addressed
    localparam int MEM_AW    = 8;
    localparam int MEM_DEPTH = 1 << MEM_AW;

    localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0000;

    typedef enum logic [3:0] {
        OP_OR     = 4'h0,
        OP_AND    = 4'h1,
        OP_ADD    = 4'h2,
        OP_MUL    = 4'h3,
        OP_RSVD   = 4'h4, // Contributes zero
        OP_SHL    = 4'h5,
        OP_CMP_LE = 4'h6,
        OP_CMP_EQ = 4'h7,
        OP_NOR    = 4'h8,
        OP_NAND   = 4'h9,
        OP_XOR    = 4'hA,
        OP_SUB    = 4'hB,
        OP_XNOR   = 4'hC,
        OP_SHR    = 4'hD,
        OP_CMP_GT = 4'hE,
        OP_CMP_NE = 4'hF
    } alu_op_e;

    // Bit 1 set means a memory write, bit 0 picks which side is the address
    typedef enum logic [1:0] {
        DR_REG       = 2'b00, // Z <- rhs
        DR_LOAD      = 2'b01, // Z <- [rhs]
        DR_STORE_Z   = 2'b10, // [Z] <- rhs
        DR_STORE_RHS = 2'b11  // [rhs] <- Z
    } deref_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_RUN  = 2'b01,
        ST_HALT = 2'b10
    } core_state_e;

endpackage

//--- design/cpu_top.sv
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_load_valid,
    input  logic [MEM_AW-1:0] i_load_addr,
    input  logic [XLEN-1:0]   i_load_data,
    input  logic              i_start,
    output logic              o_running,
    output logic              o_halt,
    output logic              o_store_valid,
    output logic [MEM_AW-1:0] o_store_addr,
    output logic [XLEN-1:0]   o_store_data
);

    logic [MEM_AW-1:0] insn_addr;
    logic [XLEN-1:0]   insn;
    logic [MEM_AW-1:0] core_addr;
    logic              core_we;
    logic [XLEN-1:0]   core_wdata;
    logic [XLEN-1:0]   core_rdata;
    logic              load_we;
    logic              mem_we;
    logic [MEM_AW-1:0] mem_waddr;
    logic [XLEN-1:0]   mem_wdata;

    cpu_core u_core (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_start     (i_start),
        .i_insn      (insn),
        .i_mem_rdata (core_rdata),
        .o_insn_addr (insn_addr),
        .o_mem_addr  (core_addr),
        .o_mem_we    (core_we),
        .o_mem_wdata (core_wdata),
        .o_running   (o_running),
        .o_halt      (o_halt)
    );

    // Program loads only land while the core is not running
    assign load_we   = i_load_valid && !o_running;
    assign mem_we    = core_we || load_we;
    assign mem_waddr = core_we ? core_addr  : i_load_addr;
    assign mem_wdata = core_we ? core_wdata : i_load_data;

    unified_mem u_mem (
        .clk         (clk),
        .i_insn_addr (insn_addr),
        .i_data_addr (core_addr),
        .i_we        (mem_we),
        .i_waddr     (mem_waddr),
        .i_wdata     (mem_wdata),
        .o_insn      (insn),
        .o_rdata     (core_rdata)
    );

    // Store report, one cycle behind the executing instruction
    always_ff @(posedge clk) begin
        if (!reset_n)
            o_store_valid <= 1'b0;
        else
            o_store_valid <= core_we;
    end

    always_ff @(posedge clk) begin
        if (core_we) begin
            o_store_addr <= core_addr;
            o_store_data <= core_wdata;
        end
    end

endmodule

//--- design/exec_unit.sv
`timescale 1ns/10ps

module exec_unit import cpu_pkg::*; (
    input  logic [XLEN-1:0] i_x,
    input  logic [XLEN-1:0] i_y,
    input  logic [XLEN-1:0] i_imm,
    input  alu_op_e         i_op,
    input  logic            i_type,
    output logic [XLEN-1:0] o_rhs
);

    logic [XLEN-1:0] o_val;  // Right operand of the op
    logic [XLEN-1:0] a_val;  // Addend
    logic [XLEN-1:0] op_res;
    logic            lt_eq;
    logic            eq;

    // Type 0 uses Y as operand and I as addend, type 1 swaps them
    assign o_val = i_type ? i_imm : i_y;
    assign a_val = i_type ? i_y   : i_imm;

    // Shared by all four compares
    assign eq    = (i_x == o_val);
    assign lt_eq = ($signed(i_x) <= $signed(o_val));

    always_comb begin
        op_res = '0;
        case (i_op)
            OP_OR:     op_res = i_x | o_val;
            OP_AND:    op_res = i_x & o_val;
            OP_ADD:    op_res = i_x + o_val;
            OP_MUL:    op_res = i_x * o_val;       // Low word only
            OP_RSVD:   op_res = '0;
            OP_SHL:    op_res = i_x << o_val;
            OP_CMP_LE: op_res = XLEN'(lt_eq);
            OP_CMP_EQ: op_res = XLEN'(eq);
            OP_NOR:    op_res = ~(i_x | o_val);
            OP_NAND:   op_res = ~(i_x & o_val);
            OP_XOR:    op_res = i_x ^ o_val;
            OP_SUB:    op_res = i_x - o_val;
            OP_XNOR:   op_res = i_x ^ ~o_val;
            OP_SHR:    op_res = i_x >> o_val;      // Logical
            OP_CMP_GT: op_res = XLEN'(!lt_eq);
            OP_CMP_NE: op_res = XLEN'(!eq);
            default:   op_res = '0;
        endcase
    end

    // Every op result is offset by the addend
    assign o_rhs = op_res + a_val;

endmodule

//--- design/insn_decode.sv
`timescale 1ns/10ps

module insn_decode import cpu_pkg::*; (
    input  logic [XLEN-1:0]   i_insn,
    output logic [REG_AW-1:0] o_z_idx,
    output logic [REG_AW-1:0] o_x_idx,
    output logic [REG_AW-1:0] o_y_idx,
    output logic [XLEN-1:0]   o_imm,
    output alu_op_e           o_op,
    output deref_e            o_deref,
    output logic              o_type,
    output logic              o_is_op,
    output logic              o_illegal
);

    logic [11:0] imm_raw;

    // Field layout
    //   31 class | 30 type | 29:28 deref | 27:24 Z | 23:20 X | 19:16 Y
    //   15:12 op | 11:0 immediate
    assign o_type  = i_insn[30];
    assign o_deref = deref_e'(i_insn[29:28]);
    assign o_z_idx = i_insn[27:24];
    assign o_x_idx = i_insn[23:20];
    assign o_y_idx = i_insn[19:16];
    assign o_op    = alu_op_e'(i_insn[15:12]);
    assign imm_raw = i_insn[11:0];

    assign o_imm = {{(XLEN-12){imm_raw[11]}}, imm_raw}; // Sign extend

    // Class 0 is a real operation
    assign o_is_op = ~i_insn[31];

    // Top nibble all ones stops the machine, other class 1 words do nothing
    assign o_illegal = &i_insn[31:28];

endmodule

//--- design/reg_file.sv
`timescale 1ns/10ps

module reg_file import cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic [REG_AW-1:0] i_rd_x_idx,
    input  logic [REG_AW-1:0] i_rd_y_idx,
    input  logic [REG_AW-1:0] i_rd_z_idx,
    input  logic [XLEN-1:0]   i_pc,
    input  logic              i_wr_en,
    input  logic [REG_AW-1:0] i_wr_idx,
    input  logic [XLEN-1:0]   i_wr_data,
    output logic [XLEN-1:0]   o_rd_x,
    output logic [XLEN-1:0]   o_rd_y,
    output logic [XLEN-1:0]   o_rd_z
);

    // Only r1..r14 are real storage
    logic [XLEN-1:0] regs [1:PC_INDEX-1];

    function automatic logic [XLEN-1:0] read_reg(input logic [REG_AW-1:0] idx);
        if (idx == '0)
            return '0;
        else if (idx == REG_AW'(PC_INDEX))
            return i_pc; // PC alias
        else
            return regs[idx];
    endfunction

    assign o_rd_x = read_reg(i_rd_x_idx);
    assign o_rd_y = read_reg(i_rd_y_idx);
    assign o_rd_z = read_reg(i_rd_z_idx);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i < PC_INDEX; i++)
                regs[i] <= '0;
        end else if (i_wr_en && i_wr_idx != '0 && i_wr_idx != REG_AW'(PC_INDEX)) begin
            regs[i_wr_idx] <= i_wr_data; // r15 handled by the core
        end
    end

endmodule

//--- design/unified_mem.sv
`timescale 1ns/10ps

module unified_mem import cpu_pkg::*; (
    input  logic              clk,
    input  logic [MEM_AW-1:0] i_insn_addr,
    input  logic [MEM_AW-1:0] i_data_addr,
    input  logic              i_we,
    input  logic [MEM_AW-1:0] i_waddr,
    input  logic [XLEN-1:0]   i_wdata,
    output logic [XLEN-1:0]   o_insn,
    output logic [XLEN-1:0]   o_rdata
);

    logic [XLEN-1:0] mem [0:MEM_DEPTH-1];

    // Both read ports are combinational
    assign o_insn  = mem[i_insn_addr];
    assign o_rdata = mem[i_data_addr];

    // Single write port, shared by loader and core
    always_ff @(posedge clk) begin
        if (i_we)
            mem[i_waddr] <= i_wdata;
    end

endmodule

//--- test/cpu_top_tb.sv
`timescale 1ns/10ps

module cpu_top_tb import cpu_pkg::*; ();

    logic              clk;
    logic              reset_n;
    logic              run_reset_n;
    logic              dut_reset_n;
    logic              i_load_valid;
    logic [MEM_AW-1:0] i_load_addr;
    logic [XLEN-1:0]   i_load_data;
    logic              i_start;
    logic              o_running;
    logic              o_halt;
    logic              o_store_valid;
    logic [MEM_AW-1:0] o_store_addr;
    logic [XLEN-1:0]   o_store_data;

    logic [XLEN-1:0]   prog [$];
    logic [XLEN-1:0]   model_mem [0:MEM_DEPTH-1];
    logic [XLEN-1:0]   model_regs [0:REG_COUNT-1];
    logic [XLEN-1:0]   model_pc;
    logic [MEM_AW-1:0] exp_addr [$];
    logic [XLEN-1:0]   exp_data [$];
    logic              idle_phase;
    logic              halt_phase;

    tb_clock u_clock (.clk(clk), .reset_n(reset_n));

    // Second reset source for reruns
    assign dut_reset_n = reset_n && run_reset_n;

    cpu_top i_cpu_top (
        .clk           (clk),
        .reset_n       (dut_reset_n),
        .i_load_valid  (i_load_valid),
        .i_load_addr   (i_load_addr),
        .i_load_data   (i_load_data),
        .i_start       (i_start),
        .o_running     (o_running),
        .o_halt        (o_halt),
        .o_store_valid (o_store_valid),
        .o_store_addr  (o_store_addr),
        .o_store_data  (o_store_data)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopping on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_run($sformatf("Mismatch %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    function automatic logic [31:0] encode_op(input logic t, input deref_e d,
            input logic [3:0] z, input logic [3:0] x, input logic [3:0] y,
            input alu_op_e op, input logic [11:0] imm);
        return {1'b0, t, d, z, x, y, op, imm};
    endfunction

    function automatic logic [11:0] rand_imm();
        return 12'($urandom);
    endfunction

    function automatic logic [31:0] fill_word(input int a);
        logic [7:0] b;
        b = 8'(a);
        return {b, ~b, b ^ 8'h5A, b + 8'h3C};
    endfunction

    function automatic logic [31:0] reg_read(input logic [3:0] idx);
        if (idx == 4'd15)
            return model_pc; // Own address
        return model_regs[idx];
    endfunction

    // X op O, then plus A
    function automatic logic [31:0] model_rhs(input logic [31:0] x, input logic [31:0] o,
                                              input logic [31:0] a, input alu_op_e op);
        logic [31:0] r;
        case (op)
            OP_OR:     r = x | o;
            OP_AND:    r = x & o;
            OP_ADD:    r = x + o;
            OP_MUL:    r = x * o;
            OP_SHL:    r = x << o;
            OP_CMP_LE: r = {31'd0, $signed(x) <= $signed(o)};
            OP_CMP_EQ: r = {31'd0, x == o};
            OP_NOR:    r = ~(x | o);
            OP_NAND:   r = ~(x & o);
            OP_XOR:    r = x ^ o;
            OP_SUB:    r = x - o;
            OP_XNOR:   r = x ^ ~o;
            OP_SHR:    r = x >> o;
            OP_CMP_GT: r = {31'd0, $signed(x) > $signed(o)};
            OP_CMP_NE: r = {31'd0, x != o};
            default:   r = '0; // Reserved
        endcase
        return r + a;
    endfunction

    task automatic record_store(input logic [7:0] addr, input logic [31:0] data);
        model_mem[addr] = data;
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic run_model();
        logic [31:0] insn;
        logic [31:0] imm;
        logic [31:0] o;
        logic [31:0] a;
        logic [31:0] rhs;
        logic [31:0] zv;
        logic [31:0] val;
        logic [31:0] next;
        logic [3:0]  zi;
        int          steps;
        bit          done;
        model_pc = RESET_VECTOR;
        for (int r = 0; r < REG_COUNT; r++)
            model_regs[r] = '0;
        done = 1'b0;
        steps = 0;
        while (!done) begin
            insn = model_mem[model_pc[7:0]];
            if (insn[31:28] == 4'hF) begin
                done = 1'b1;
            end else if (insn[31]) begin
                model_pc = model_pc + 1; // No-op
            end else begin
                zi = insn[27:24];
                imm = {{20{insn[11]}}, insn[11:0]};
                o = insn[30] ? imm : reg_read(insn[19:16]);
                a = insn[30] ? reg_read(insn[19:16]) : imm;
                rhs = model_rhs(reg_read(insn[23:20]), o, a, alu_op_e'(insn[15:12]));
                zv = reg_read(zi);
                next = model_pc + 1;
                case (deref_e'(insn[29:28]))
                    DR_STORE_Z:   record_store(zv[7:0], rhs);
                    DR_STORE_RHS: record_store(rhs[7:0], zv);
                    default: begin
                        val = (insn[29:28] == DR_LOAD) ? model_mem[rhs[7:0]] : rhs;
                        if (zi == 4'd15)
                            next = val; // Jump
                        else if (zi != 4'd0)
                            model_regs[zi] = val;
                    end
                endcase
                model_pc = next;
            end
            steps++;
            if (steps > 400)
                stop_run("reference model never reached an illegal word");
        end
    endtask

    task automatic build_alu_program();
        prog.delete();
        prog.push_back(encode_op(0, DR_REG, 1, 0, 0, OP_OR, rand_imm()));
        prog.push_back(encode_op(1, DR_REG, 1, 1, 0, OP_SHL, 12'd20));
        prog.push_back(encode_op(0, DR_REG, 1, 1, 0, OP_XOR, rand_imm()));
        prog.push_back(encode_op(0, DR_REG, 2, 0, 0, OP_OR, rand_imm()));
        prog.push_back(encode_op(1, DR_REG, 2, 2, 0, OP_SHL, 12'd16));
        prog.push_back(encode_op(0, DR_REG, 2, 2, 0, OP_XOR, rand_imm()));
        prog.push_back(encode_op(0, DR_REG, 3, 0, 0, OP_OR, 12'($urandom % 32))); // Shift amount
        prog.push_back(encode_op(0, DR_REG, 4, 1, 0, OP_OR, 12'd0)); // Copy of r1
        prog.push_back(encode_op(0, DR_REG, 5, 0, 0, OP_OR, 12'h080)); // Store pointer
        for (int k = 0; k < 16; k++) begin
            prog.push_back(encode_op(0, DR_STORE_Z, 5, 1, 3, alu_op_e'(k), rand_imm()));
            prog.push_back(encode_op(0, DR_REG, 5, 5, 0, OP_ADD, 12'd1));
            prog.push_back(encode_op(1, DR_STORE_Z, 5, 1, 2, alu_op_e'(k), rand_imm()));
            prog.push_back(encode_op(0, DR_REG, 5, 5, 0, OP_ADD, 12'd1));
            prog.push_back(encode_op(0, DR_STORE_Z, 5, 1, 4, alu_op_e'(k), rand_imm()));
            prog.push_back(encode_op(0, DR_REG, 5, 5, 0, OP_ADD, 12'd1));
        end
        prog.push_back(32'hF000_0000 | 32'($urandom % 32'h0FFF_FFFF));
        prog.push_back(encode_op(0, DR_STORE_Z, 5, 1, 2, OP_ADD, 12'd0)); // Never runs
    endtask

    task automatic build_memory_program();
        prog.delete();
        prog.push_back(encode_op(0, DR_REG, 6, 0, 0, OP_OR, 12'h040));
        prog.push_back(encode_op(0, DR_REG, 7, 0, 0, OP_OR, rand_imm()));
        prog.push_back(encode_op(0, DR_STORE_RHS, 7, 6, 0, OP_OR, 12'd0));
        prog.push_back(encode_op(0, DR_LOAD, 8, 6, 0, OP_OR, 12'd0)); // Read back
        prog.push_back(encode_op(0, DR_STORE_RHS, 8, 6, 0, OP_OR, 12'd1));
        prog.push_back(encode_op(1, DR_LOAD, 9, 0, 0, OP_OR, 12'h030)); // Fill word
        prog.push_back(encode_op(0, DR_STORE_Z, 6, 9, 0, OP_ADD, 12'd0));
        prog.push_back(32'h9ABC_DEF0);
        prog.push_back(encode_op(0, DR_REG, 0, 7, 0, OP_OR, rand_imm())); // Dropped
        prog.push_back(encode_op(0, DR_STORE_RHS, 0, 6, 0, OP_OR, 12'd2));
        prog.push_back(encode_op(0, DR_STORE_RHS, 15, 6, 0, OP_OR, 12'd3));
        prog.push_back(encode_op(0, DR_REG, 15, 15, 0, OP_OR, 12'd3)); // Skip two words
        prog.push_back(encode_op(0, DR_STORE_RHS, 7, 6, 0, OP_OR, 12'd4));
        prog.push_back(encode_op(0, DR_STORE_RHS, 8, 6, 0, OP_OR, 12'd5));
        prog.push_back(encode_op(0, DR_STORE_RHS, 15, 6, 0, OP_OR, 12'd6));
        prog.push_back(32'hF123_4567);
        prog.push_back(encode_op(0, DR_STORE_RHS, 7, 6, 0, OP_OR, 12'd7));
    endtask

    // Rewrites every word with the program at the bottom
    task automatic load_memory();
        logic [31:0] word;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            word = (a < prog.size()) ? prog[a] : fill_word(a);
            model_mem[a] = word;
            @(posedge clk);
            i_load_valid <= 1'b1;
            i_load_addr  <= MEM_AW'(a);
            i_load_data  <= word;
        end
        @(posedge clk);
        i_load_valid <= 1'b0;
    endtask

    task automatic wait_for_por();
        int cycles;
        cycles = 0;
        while (!reset_n) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20)
                stop_run("power-on reset never released");
        end
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 1000)
                stop_run("timeout waiting for the core to halt");
            if (!o_halt)
                assert (o_running)
                else stop_run("core was not running before it halted");
        end while (!o_halt);
    endtask

    task automatic run_program();
        @(posedge clk);
        run_reset_n <= 1'b0;
        repeat (3) @(posedge clk);
        run_reset_n <= 1'b1;
        @(posedge clk);
        idle_phase = 1'b1;
        load_memory();
        run_model();
        repeat (3) @(posedge clk);
        i_start <= 1'b1;
        idle_phase = 1'b0;
        @(posedge clk);
        i_start <= 1'b0;
        wait_for_halt();
        @(posedge clk);
        halt_phase = 1'b1; // Quiet window after halt
        repeat (20) @(posedge clk);
        halt_phase = 1'b0;
        assert (exp_addr.size() == 0)
        else stop_run("expected stores never appeared");
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (idle_phase)
            assert (!o_running && !o_halt && !o_store_valid)
            else stop_run("core left idle before start");
        if (halt_phase)
            assert (o_halt && !o_running)
            else stop_run("halt state was not held");
        if (o_store_valid) begin
            assert (exp_addr.size() != 0)
            else stop_run("store strobe with no store expected");
            assert (o_store_addr == exp_addr[0])
            else report_mismatch("o_store_addr", 32'(o_store_addr), 32'(exp_addr[0]));
            assert (o_store_data == exp_data[0])
            else report_mismatch("o_store_data", o_store_data, exp_data[0]);
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end
    end

    initial begin
        void'($urandom(32'h3275));
        run_reset_n  = 1'b1;
        i_load_valid = 1'b0;
        i_load_addr  = '0;
        i_load_data  = '0;
        i_start      = 1'b0;
        idle_phase   = 1'b0;
        halt_phase   = 1'b0;
        wait_for_por();
        build_alu_program();
        run_program();
        build_memory_program(); // Rerun after a fresh reset
        run_program();
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    // Power-on reset, 3 cycles
    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule
